//--- design/wh_pkg.sv
// flit format widths and wormhole flit, coordinate, length, header and data types
package wh_pkg;

  // link flit width
  localparam int flit_width_c = 32;
  // destination coordinate, low bits of the first header flit
  localparam int cord_width_c = 4;
  // wormhole length field, total flits minus one
  localparam int len_width_c  = 4;
  // most data words one message can carry
  localparam int max_data_c   = 4;

  // protocol header bits riding in the first header flit above cord and len
  localparam int hdr_lo_width_c = flit_width_c - cord_width_c - len_width_c;
  // remaining protocol header bits, one full second header flit
  localparam int hdr_hi_width_c = flit_width_c;
  localparam int hdr_width_c    = hdr_lo_width_c + hdr_hi_width_c;

  // bit offsets inside the first header flit
  localparam int len_lsb_c    = cord_width_c;
  localparam int hdr_lo_lsb_c = cord_width_c + len_width_c;

  typedef logic [flit_width_c-1:0] flit_t;
  typedef logic [cord_width_c-1:0] cord_t;

  // also used for the data word count of a message
  typedef logic [len_width_c-1:0] len_t;

  typedef logic [hdr_width_c-1:0] msg_hdr_t;

  // word 0 goes out first
  typedef logic [max_data_c-1:0][flit_width_c-1:0] msg_data_t;

  // flit position inside the header or data phase
  typedef logic [$clog2(max_data_c)-1:0] word_idx_t;

endpackage

//--- design/wh_stream_if.sv
`timescale 1ns/10ps
// interface for the header/data position flags of a wormhole flit stream
interface wh_stream_if;

  // current flit is a header flit
  logic is_hdr;
  // current flit is the final header flit
  logic last_hdr;
  // packet carries data flits after the header
  logic has_data;
  // current flit is a data flit
  logic is_data;
  // current flit is the final data flit
  logic last_data;

  // stream control drives all flags
  modport ctrl (output is_hdr, last_hdr, has_data, is_data, last_data);

  // packetizer or depacketizer only reads them
  modport user (input is_hdr, last_hdr, has_data, is_data, last_data);

endinterface

//--- design/wh_counter_set_down.sv
`timescale 1ns/10ps
// loadable down counter, load and decrement allowed in the same cycle
module wh_counter_set_down #(
  parameter int width_p = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               set_i,
  input  logic [width_p-1:0] val_i,
  input  logic               down_i,
  output logic [width_p-1:0] count_o
);

  logic [width_p-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (set_i) begin
      // load already counts the flit taken this cycle, no bubble
      count_r <= val_i - width_p'(down_i);
    end else if (down_i && (count_r != '0)) begin
      // saturate at zero
      count_r <= count_r - width_p'(1);
    end
  end

  assign count_o = count_r;

endmodule

//--- design/wh_stream_control.sv
`timescale 1ns/10ps
// header/data FSM with header and data flit counters for a wormhole stream
module wh_stream_control
  import wh_pkg::*;
#(
  parameter int hdr_len_p = 2
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  len_t        len_i,
  input  logic        link_accept_i,
  wh_stream_if.ctrl   flags
);

  typedef enum logic {
    st_hdr_e,
    st_data_e
  } state_t;

  state_t state_r;
  state_t state_n;

  logic is_hdr;
  logic is_data;

  // length field is flits minus one, so this gives the data flit count
  len_t data_len;

  // counters run from flit count down to zero, one means last flit
  len_t hdr_cnt;
  len_t data_cnt;

  logic hdr_last;
  logic hdr_done;
  logic data_last;
  logic data_done;

  logic set_counter;
  logic hdr_to_data;
  logic data_to_hdr;

  assign is_hdr  = (state_r == st_hdr_e);
  assign is_data = (state_r == st_data_e);

  assign data_len = len_i - len_t'(hdr_len_p) + len_t'(1);

  assign hdr_last  = (hdr_cnt == len_t'(1));
  assign hdr_done  = (hdr_cnt == '0);
  assign data_last = (data_cnt == len_t'(1));
  assign data_done = (data_cnt == '0);

  // both counters load on the first header flit of a packet
  assign set_counter = is_hdr & hdr_done & link_accept_i;

  wh_counter_set_down #(
    .width_p(len_width_c)
  ) hdr_counter (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .set_i  (set_counter),
    .val_i  (len_t'(hdr_len_p)),
    .down_i (is_hdr & link_accept_i),
    .count_o(hdr_cnt)
  );

  wh_counter_set_down #(
    .width_p(len_width_c)
  ) data_counter (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .set_i  (set_counter),
    .val_i  (data_len),
    .down_i (is_data & link_accept_i),
    .count_o(data_cnt)
  );

  if (hdr_len_p == 1) begin : g_single_hdr
    // every header flit is the first one, len_i of the flit itself is valid
    assign flags.last_hdr = is_hdr;
    assign flags.has_data = is_hdr & (data_len != '0);
  end else begin : g_multi_hdr
    // len_i is only valid on the first flit, use the loaded data counter
    assign flags.last_hdr = is_hdr & hdr_last;
    assign flags.has_data = is_hdr & ~data_done;
  end

  assign flags.is_hdr    = is_hdr;
  assign flags.is_data   = is_data;
  assign flags.last_data = is_data & data_last;

  assign hdr_to_data = link_accept_i & flags.last_hdr & flags.has_data;
  assign data_to_hdr = link_accept_i & data_last;

  always_comb begin
    case (state_r)
      st_hdr_e:  state_n = hdr_to_data ? st_data_e : st_hdr_e;
      st_data_e: state_n = data_to_hdr ? st_hdr_e : st_data_e;
      default:   state_n = st_hdr_e;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_hdr_e;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

//--- design/wh_packetizer.sv
`timescale 1ns/10ps
// one-message buffer that sends header and data flits under link back-pressure
module wh_packetizer
  import wh_pkg::*;
#(
  parameter int hdr_len_p = 2
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      msg_v_i,
  output logic      msg_ready_o,
  input  cord_t     msg_cord_i,
  input  msg_hdr_t  msg_hdr_i,
  input  len_t      msg_count_i,
  input  msg_data_t msg_data_i,
  output logic      link_v_o,
  output flit_t     link_data_o,
  input  logic      link_ready_i
);

  wh_stream_if flags ();

  // message held while its flits go out
  logic      busy_r;
  cord_t     cord_r;
  msg_hdr_t  hdr_r;
  len_t      count_r;
  msg_data_t data_r;

  // flit index inside the current phase
  word_idx_t idx_r;

  logic  msg_take;
  logic  link_accept;
  logic  last_flit;
  len_t  len_field;
  flit_t hdr_flit;

  assign msg_ready_o = ~busy_r;
  assign msg_take    = msg_v_i & msg_ready_o;

  assign link_v_o    = busy_r;
  assign link_accept = link_v_o & link_ready_i;

  // wormhole length is total flits minus one
  assign len_field = len_t'(hdr_len_p) + count_r - len_t'(1);

  wh_stream_control #(
    .hdr_len_p(hdr_len_p)
  ) stream_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .len_i        (len_field),
    .link_accept_i(link_accept),
    .flags        (flags)
  );

  // first header flit packs low header bits over len and cord
  always_comb begin
    if (idx_r == '0) begin
      hdr_flit = {hdr_r[hdr_lo_width_c-1:0], len_field, cord_r};
    end else begin
      hdr_flit = hdr_r[hdr_width_c-1:hdr_lo_width_c];
    end
  end

  // registers only change on accept, so data holds under back-pressure
  assign link_data_o = flags.is_hdr ? hdr_flit : data_r[idx_r];

  // packet ends on the last data flit, or the last header with no data
  assign last_flit = flags.last_data | (flags.last_hdr & ~flags.has_data);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else if (msg_take) begin
      busy_r <= 1'b1;
      idx_r  <= '0;
    end else if (link_accept) begin
      busy_r <= ~last_flit;
      // index restarts at each phase boundary
      if (flags.last_hdr || flags.last_data) begin
        idx_r <= '0;
      end else begin
        idx_r <= idx_r + word_idx_t'(1);
      end
    end
  end

  // payload capture
  always_ff @(posedge clk_i) begin
    if (msg_take) begin
      cord_r  <= msg_cord_i;
      hdr_r   <= msg_hdr_i;
      count_r <= msg_count_i;
      data_r  <= msg_data_i;
    end
  end

endmodule

//--- design/wh_depacketizer.sv
`timescale 1ns/10ps
// flit collector that rebuilds a message and strobes it after the last flit
module wh_depacketizer
  import wh_pkg::*;
#(
  parameter int hdr_len_p = 2
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      link_v_i,
  input  flit_t     link_data_i,
  output logic      msg_v_o,
  output cord_t     msg_cord_o,
  output msg_hdr_t  msg_hdr_o,
  output len_t      msg_count_o,
  output msg_data_t msg_data_o
);

  wh_stream_if flags ();

  logic      msg_v_r;
  cord_t     cord_r;
  msg_hdr_t  hdr_r;
  len_t      count_r;
  msg_data_t data_r;
  word_idx_t idx_r;

  len_t flit_len;
  logic last_flit;

  // len field only means something on the first header flit
  assign flit_len = link_data_i[len_lsb_c +: len_width_c];

  // no back-pressure, every valid flit counts as accepted
  wh_stream_control #(
    .hdr_len_p(hdr_len_p)
  ) stream_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .len_i        (flit_len),
    .link_accept_i(link_v_i),
    .flags        (flags)
  );

  assign last_flit = flags.last_data | (flags.last_hdr & ~flags.has_data);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      msg_v_r <= 1'b0;
      idx_r   <= '0;
    end else begin
      // one-cycle strobe from the edge that takes the last flit
      msg_v_r <= link_v_i & last_flit;
      if (link_v_i) begin
        if (flags.last_hdr || flags.last_data) begin
          idx_r <= '0;
        end else begin
          idx_r <= idx_r + word_idx_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (link_v_i && flags.is_hdr && (idx_r == '0)) begin
      cord_r                     <= link_data_i[cord_width_c-1:0];
      hdr_r[hdr_lo_width_c-1:0]  <= link_data_i[flit_width_c-1:hdr_lo_lsb_c];
      // high header bits stay zero unless a second header flit comes
      hdr_r[hdr_width_c-1:hdr_lo_width_c] <= '0;
      count_r <= flit_len - len_t'(hdr_len_p) + len_t'(1);
      // words beyond the count read as zero
      data_r  <= '0;
    end else if (link_v_i && flags.is_hdr) begin
      hdr_r[hdr_width_c-1:hdr_lo_width_c] <= link_data_i;
    end else if (link_v_i && flags.is_data) begin
      data_r[idx_r] <= link_data_i;
    end
  end

  assign msg_v_o     = msg_v_r;
  assign msg_cord_o  = cord_r;
  assign msg_hdr_o   = hdr_r;
  assign msg_count_o = count_r;
  assign msg_data_o  = data_r;

endmodule

//--- design/wh_loop_top.sv
`timescale 1ns/10ps
// top level with packetizer on the send side and depacketizer on the receive side
module wh_loop_top
  import wh_pkg::*;
#(
  parameter int hdr_len_p = 2
) (
  input  logic      clk_i,
  input  logic      reset_i,

  // message in
  input  logic      msg_v_i,
  output logic      msg_ready_o,
  input  cord_t     msg_cord_i,
  input  msg_hdr_t  msg_hdr_i,
  input  len_t      msg_count_i,
  input  msg_data_t msg_data_i,

  // link out
  output logic      link_v_o,
  output flit_t     link_data_o,
  input  logic      link_ready_i,

  // link in
  input  logic      link_v_i,
  input  flit_t     link_data_i,

  // message out
  output logic      msg_v_o,
  output cord_t     msg_cord_o,
  output msg_hdr_t  msg_hdr_o,
  output len_t      msg_count_o,
  output msg_data_t msg_data_o
);

  wh_packetizer #(
    .hdr_len_p(hdr_len_p)
  ) tx (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .msg_v_i     (msg_v_i),
    .msg_ready_o (msg_ready_o),
    .msg_cord_i  (msg_cord_i),
    .msg_hdr_i   (msg_hdr_i),
    .msg_count_i (msg_count_i),
    .msg_data_i  (msg_data_i),
    .link_v_o    (link_v_o),
    .link_data_o (link_data_o),
    .link_ready_i(link_ready_i)
  );

  // receive side sees the link stream directly, no extra stage
  wh_depacketizer #(
    .hdr_len_p(hdr_len_p)
  ) rx (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .link_v_i   (link_v_i),
    .link_data_i(link_data_i),
    .msg_v_o    (msg_v_o),
    .msg_cord_o (msg_cord_o),
    .msg_hdr_o  (msg_hdr_o),
    .msg_count_o(msg_count_o),
    .msg_data_o (msg_data_o)
  );

endmodule

//--- tests/wh_props.sv
`timescale 1ns/10ps
// concurrent assertions on the stream control phase and flit counters
module wh_props
  import wh_pkg::*;
(
  input logic clk_i,
  input logic reset_i,
  input logic link_accept_i,
  input logic is_hdr,
  input logic is_data,
  input logic last_hdr,
  input logic has_data,
  input logic last_data,
  input len_t hdr_cnt,
  input len_t data_cnt
);

  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // data phase always has at least one data flit left
  a_data_cnt_live: assert property (@(posedge clk_i) disable iff (reset_i)
    is_data |-> (data_cnt != '0))
    else begin
      fail_count++;
      $error("data phase with the data counter at zero");
    end

  // last data flit taken, back to an idle header phase
  a_last_data_ends: assert property (@(posedge clk_i) disable iff (reset_i)
    (last_data && link_accept_i) |=> (is_hdr && hdr_cnt == '0 && data_cnt == '0))
    else begin
      fail_count++;
      $error("stream control not idle after the last data flit");
    end

  // header-only packet ends on its last header flit
  a_hdr_only_ends: assert property (@(posedge clk_i) disable iff (reset_i)
    (last_hdr && !has_data && link_accept_i) |=>
      (is_hdr && hdr_cnt == '0 && data_cnt == '0))
    else begin
      fail_count++;
      $error("stream control not idle after a header-only packet");
    end

endmodule

//--- tests/wh_tb.sv
`timescale 1ns/10ps
// loopback testbench with random messages, random link ready and scoreboard checks
module wh_tb
  import wh_pkg::*;
#(
  parameter int hdr_len_p = 2
);

  localparam int num_msgs_c     = 40;
  localparam int timeout_c      = 200;
  localparam int reset_cycles_c = 10;

  // one message as seen on the message ports
  typedef struct packed {
    cord_t     cord;
    msg_hdr_t  hdr;
    len_t      count;
    msg_data_t data;
  } msg_t;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      msg_v_i;
  logic      msg_ready_o;
  cord_t     msg_cord_i;
  msg_hdr_t  msg_hdr_i;
  len_t      msg_count_i;
  msg_data_t msg_data_i;
  logic      link_v_o;
  flit_t     link_data_o;
  logic      link_ready_i;
  logic      link_v_i;
  flit_t     link_data_i;
  logic      msg_v_o;
  cord_t     msg_cord_o;
  msg_hdr_t  msg_hdr_o;
  len_t      msg_count_o;
  msg_data_t msg_data_o;

  // taken messages still on the link, and messages still to come back
  msg_t sent_q[$];
  msg_t exp_q[$];
  msg_t cur;
  msg_t taken;
  int   flit_cnt;
  logic stall_r;
  flit_t stall_data_r;
  logic msg_v_prev;
  int   error_count;
  int   timeout_count;
  int   prop_fails;
  int   rx_count;
  int   zero_rx;

  always #20 clk_i = ~clk_i;

  wh_loop_top #(
    .hdr_len_p(hdr_len_p)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .msg_v_i     (msg_v_i),
    .msg_ready_o (msg_ready_o),
    .msg_cord_i  (msg_cord_i),
    .msg_hdr_i   (msg_hdr_i),
    .msg_count_i (msg_count_i),
    .msg_data_i  (msg_data_i),
    .link_v_o    (link_v_o),
    .link_data_o (link_data_o),
    .link_ready_i(link_ready_i),
    .link_v_i    (link_v_i),
    .link_data_i (link_data_i),
    .msg_v_o     (msg_v_o),
    .msg_cord_o  (msg_cord_o),
    .msg_hdr_o   (msg_hdr_o),
    .msg_count_o (msg_count_o),
    .msg_data_o  (msg_data_o)
  );

  // loopback, receiver only sees flits the sender got accepted
  assign link_v_i    = link_v_o & link_ready_i;
  assign link_data_i = link_data_o;

  bind wh_stream_control wh_props i_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_accept_i(link_accept_i),
    .is_hdr       (is_hdr),
    .is_data      (is_data),
    .last_hdr     (flags.last_hdr),
    .has_data     (flags.has_data),
    .last_data    (flags.last_data),
    .hdr_cnt      (hdr_cnt),
    .data_cnt     (data_cnt)
  );

  // roughly 70% ready
  always @(posedge clk_i) begin
    #2;
    link_ready_i = ($urandom_range(0, 9) < 7);
  end

  task automatic report_mismatch(input string what);
    error_count++;
    $display("Error at %0t: %s", $realtime, what);
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("at %0t: %s", $realtime, what);
  endtask

  task automatic check_idle();
    assert (link_v_o === 1'b0) else report_mismatch("link_v_o not low around reset");
    assert (msg_v_o === 1'b0) else report_mismatch("msg_v_o not low around reset");
    assert (msg_ready_o === 1'b1) else report_mismatch("msg_ready_o not high around reset");
  endtask

  // unused words come back as zero, one header flit drops the high header bits
  function automatic msg_t expected_msg(input msg_t m);
    msg_t e;
    e = m;
    if (hdr_len_p == 1) begin
      e.hdr[55:24] = '0;
    end
    for (int w = 0; w < max_data_c; w++) begin
      if (w >= int'(m.count)) begin
        e.data[w] = '0;
      end
    end
    return e;
  endfunction

  task automatic send_msg(input int idx);
    int cycles;
    @(posedge clk_i);
    #2;
    msg_cord_i  = cord_t'($urandom);
    msg_hdr_i   = msg_hdr_t'({$urandom, $urandom});
    // first message has no data so the header-only path is always taken
    msg_count_i = (idx == 0) ? len_t'(0) : len_t'($urandom_range(0, max_data_c));
    for (int w = 0; w < max_data_c; w++) begin
      msg_data_i[w] = $urandom;
    end
    msg_v_i = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!msg_ready_o && cycles < timeout_c) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!msg_ready_o) begin
      timeout_count++;
      $display("at %0t: timeout, msg_ready_o stayed low for %0d cycles", $realtime, timeout_c);
    end
    @(posedge clk_i);
    #2;
    msg_v_i = 1'b0;
  endtask

  // scoreboard, sampled mid-cycle where everything is settled
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (link_v_o && link_ready_i) begin
        assert (sent_q.size() != 0) else report_problem("flit accepted with no message taken");
        if (sent_q.size() != 0) begin
          cur = sent_q[0];
          if (flit_cnt == 0) begin
            assert (link_data_o[3:0] == cur.cord)
              else report_mismatch($sformatf("first flit cord %0h, expected %0h",
                                             link_data_o[3:0], cur.cord));
            assert (link_data_o[7:4] == len_t'(hdr_len_p + int'(cur.count) - 1))
              else report_mismatch($sformatf("first flit len %0d, count %0d",
                                             link_data_o[7:4], cur.count));
          end
          flit_cnt++;
          if (flit_cnt == hdr_len_p + int'(cur.count)) begin
            void'(sent_q.pop_front());
            flit_cnt = 0;
          end
        end
      end
      // ready early means flits went missing
      if (msg_ready_o) begin
        assert (flit_cnt == 0 && sent_q.size() == 0)
          else report_problem("msg_ready_o high before all flits of a packet were sent");
      end
      if (msg_v_i && msg_ready_o) begin
        taken.cord  = msg_cord_i;
        taken.hdr   = msg_hdr_i;
        taken.count = msg_count_i;
        taken.data  = msg_data_i;
        sent_q.push_back(taken);
        exp_q.push_back(expected_msg(taken));
      end
      if (stall_r) begin
        assert (link_data_o == stall_data_r) else report_mismatch("link_data_o changed in stall");
      end
      stall_r      = link_v_o && !link_ready_i;
      stall_data_r = link_data_o;
      assert (!(msg_v_o && msg_v_prev)) else report_mismatch("msg_v_o high for two cycles");
      msg_v_prev = msg_v_o;
      if (msg_v_o) begin
        assert (exp_q.size() != 0) else report_problem("message received with none expected");
        if (exp_q.size() != 0) begin
          cur = exp_q.pop_front();
          assert (msg_cord_o == cur.cord)
            else report_mismatch($sformatf("cord %0h, expected %0h", msg_cord_o, cur.cord));
          assert (msg_hdr_o == cur.hdr)
            else report_mismatch($sformatf("hdr %0h, expected %0h", msg_hdr_o, cur.hdr));
          assert (msg_count_o == cur.count)
            else report_mismatch($sformatf("count %0d, expected %0d", msg_count_o, cur.count));
          assert (msg_data_o == cur.data)
            else report_mismatch($sformatf("data %0h, expected %0h", msg_data_o, cur.data));
          rx_count++;
          if (cur.count == '0) begin
            zero_rx++;
          end
        end
      end
    end
  end

  initial begin
    int cycles;
    void'($urandom(32'h6df2));
    $timeformat(-9, 2, " ns", 0);
    error_count   = 0;
    timeout_count = 0;
    prop_fails    = 0;
    rx_count      = 0;
    zero_rx       = 0;
    flit_cnt      = 0;
    stall_r       = 1'b0;
    stall_data_r  = '0;
    msg_v_prev    = 1'b0;
    reset_i       = 1'b1;
    msg_v_i       = 1'b0;
    msg_cord_i    = '0;
    msg_hdr_i     = '0;
    msg_count_i   = '0;
    msg_data_i    = '0;
    link_ready_i  = 1'b0;
    repeat (reset_cycles_c - 1) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle();
    for (int i = 0; i < num_msgs_c && timeout_count == 0; i++) begin
      send_msg(i);
    end
    // wait for the receiver to hand back everything
    cycles = 0;
    while (exp_q.size() != 0 && cycles < timeout_c) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      timeout_count++;
      $display("at %0t: timeout, %0d messages never came back", $realtime, exp_q.size());
    end
    repeat (2) @(posedge clk_i);
    #1;
    prop_fails = i_dut.tx.stream_ctrl.i_props.fail_count +
                 i_dut.rx.stream_ctrl.i_props.fail_count;
    assert (zero_rx > 0) else report_problem("no message without data words came back");
    assert (rx_count == num_msgs_c)
      else report_problem($sformatf("%0d messages came back, %0d sent", rx_count, num_msgs_c));
    $display("%0d errors, %0d timeouts, %0d property failures, %0d messages checked",
             error_count, timeout_count, prop_fails, rx_count);
    if (error_count == 0 && timeout_count == 0 && prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sim.f
design/wh_pkg.sv
design/wh_stream_if.sv
design/wh_counter_set_down.sv
design/wh_stream_control.sv
design/wh_packetizer.sv
design/wh_depacketizer.sv
design/wh_loop_top.sv
tests/wh_props.sv
tests/wh_tb.sv

//--- Bender.yml
package:
  name: wh_loop

sources:
  - files:
      - design/wh_pkg.sv
      - design/wh_stream_if.sv
      - design/wh_counter_set_down.sv
      - design/wh_stream_control.sv
      - design/wh_packetizer.sv
      - design/wh_depacketizer.sv
      - design/wh_loop_top.sv
  - target: test
    files:
      - tests/wh_props.sv
      - tests/wh_tb.sv
